// File: csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define CSR_XLEN 32

// Machine CSR addresses
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MIE       12'h304
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MTVAL     12'h343
`define CSR_ADDR_MIP       12'h344
`define CSR_ADDR_MCYCLE    12'hB00
`define CSR_ADDR_MINSTRET  12'hB02
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID   12'hF12
`define CSR_ADDR_MIMPID    12'hF13
`define CSR_ADDR_MHARTID   12'hF14

`define PRIV_M 2'b11
`define PRIV_U 2'b00

`define CAUSE_ILLEGAL 4'd2
`define CAUSE_ECALL_U 4'd8
`define CAUSE_ECALL_M 4'd11

`define MARCHID_VAL 32'd13
`define MIMPID_VAL  32'd1
// MXL=1, extensions I, M, A and U
`define MISA_VAL    32'h4010_1101

`define MIE_MASK     32'h0000_0888
// mpp, mpie and mie only
`define MSTATUS_MASK 32'h0000_1888

`endif

// File: csr_pkg.sv
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

   typedef enum logic [3:0]
   {
      e_none   = 4'd0,
      e_csrrw  = 4'd1,
      e_csrrs  = 4'd2,
      e_csrrc  = 4'd3,
      e_csrrwi = 4'd4,
      e_csrrsi = 4'd5,
      e_csrrci = 4'd6,
      e_ecall  = 4'd7,
      e_mret   = 4'd8
   } csr_op_e;

   // Immediate forms take data[4:0]
   typedef struct packed
   {
      csr_op_e              op;
      logic [11:0]          addr;
      logic [`CSR_XLEN-1:0] data;
   } csr_cmd_s;

   typedef struct packed
   {
      logic [18:0] rsvd_hi;
      logic [1:0]  mpp;
      logic [2:0]  rsvd_mid;
      logic        mpie;
      logic [2:0]  rsvd_lo;
      logic        mie;
      logic [2:0]  rsvd_uie;
   } mstatus_fields_s;

   typedef union packed
   {
      logic [`CSR_XLEN-1:0] word;
      mstatus_fields_s      f;
   } mstatus_u;

   typedef struct packed
   {
      logic [1:0]           priv;
      mstatus_u             mstatus;
      logic [`CSR_XLEN-1:0] mie;
      logic [`CSR_XLEN-1:0] mip;
      logic [`CSR_XLEN-1:0] mtvec;
      logic [`CSR_XLEN-1:0] mscratch;
      logic [`CSR_XLEN-1:0] mepc;
      logic [`CSR_XLEN-1:0] mcause;
      logic [`CSR_XLEN-1:0] mtval;
      logic [`CSR_XLEN-1:0] mcycle;
      logic [`CSR_XLEN-1:0] minstret;
   } csr_state_s;

   typedef struct packed
   {
      logic                 we;
      logic [11:0]          addr;
      logic [`CSR_XLEN-1:0] data;
   } csr_write_s;

   typedef struct packed
   {
      logic       exc_v;
      logic       int_v;
      logic [3:0] exc_code;
      logic [3:0] int_code;
   } trap_req_s;

   typedef logic [15:0] exc_vec_t;

   typedef struct packed
   {
      logic                 v;
      logic                 exception;
      logic                 interrupt;
      logic                 eret;
      logic [`CSR_XLEN-1:0] npc;
      logic [1:0]           priv_n;
   } commit_pkt_s;

endpackage

`default_nettype wire

// File: csr_access.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_access
(
   input  csr_pkg::csr_cmd_s    cmd_i,
   input  logic                 cmd_v_i,
   input  csr_pkg::csr_state_s  state_i,
   output logic [`CSR_XLEN-1:0] rdata_o,
   output csr_pkg::csr_write_s  wr_o,
   output logic                 illegal_o
);
   import csr_pkg::*;

   logic                 is_csr;
   logic                 is_imm;
   logic                 priv_ok;
   logic                 addr_ok;
   logic                 legal;
   logic [`CSR_XLEN-1:0] rval;
   logic [`CSR_XLEN-1:0] src;
   logic [`CSR_XLEN-1:0] wval;
   logic [`CSR_XLEN-1:0] wdata;

   assign is_csr  = cmd_i.op inside {e_csrrw, e_csrrs, e_csrrc, e_csrrwi, e_csrrsi, e_csrrci};
   assign is_imm  = cmd_i.op inside {e_csrrwi, e_csrrsi, e_csrrci};
   assign priv_ok = state_i.priv >= cmd_i.addr[9:8];
   assign src     = is_imm ? {{(`CSR_XLEN-5){1'b0}}, cmd_i.data[4:0]} : cmd_i.data;

   // Read mux, unknown address clears addr_ok
   always_comb
   begin
      addr_ok = 1'b1;
      rval    = '0;
      case (cmd_i.addr)
         `CSR_ADDR_MSTATUS:   rval = state_i.mstatus.word;
         `CSR_ADDR_MISA:      rval = `MISA_VAL;
         `CSR_ADDR_MIE:       rval = state_i.mie;
         `CSR_ADDR_MTVEC:     rval = state_i.mtvec;
         `CSR_ADDR_MSCRATCH:  rval = state_i.mscratch;
         `CSR_ADDR_MEPC:      rval = state_i.mepc;
         `CSR_ADDR_MCAUSE:    rval = state_i.mcause;
         `CSR_ADDR_MTVAL:     rval = state_i.mtval;
         `CSR_ADDR_MIP:       rval = state_i.mip;
         `CSR_ADDR_MCYCLE:    rval = state_i.mcycle;
         `CSR_ADDR_MINSTRET:  rval = state_i.minstret;
         `CSR_ADDR_MARCHID:   rval = `MARCHID_VAL;
         `CSR_ADDR_MIMPID:    rval = `MIMPID_VAL;
         `CSR_ADDR_MVENDORID,
         `CSR_ADDR_MHARTID:   rval = '0;
         default:             addr_ok = 1'b0;
      endcase
   end

   always_comb
   begin
      unique case (cmd_i.op)
         e_csrrw, e_csrrwi: wval = src;
         e_csrrs, e_csrrsi: wval = rval | src;
         e_csrrc, e_csrrci: wval = rval & ~src;
         default:           wval = rval;
      endcase
   end

   // WARL legalization per register
   always_comb
   begin
      wdata = wval;
      case (cmd_i.addr)
         `CSR_ADDR_MSTATUS:
         begin
            wdata        = wval & `MSTATUS_MASK;
            // mpp holds only M or U
            wdata[12:11] = {2{&wval[12:11]}};
         end
         `CSR_ADDR_MIE:   wdata = wval & `MIE_MASK;
         `CSR_ADDR_MTVEC: wdata = {wval[`CSR_XLEN-1:2], 2'b00};
         `CSR_ADDR_MEPC:  wdata = {wval[`CSR_XLEN-1:1], 1'b0};
         default:         wdata = wval;
      endcase
   end

   assign legal = cmd_v_i && is_csr && priv_ok && addr_ok;

   assign illegal_o = cmd_v_i
                    && ((is_csr && !(priv_ok && addr_ok))
                       || (cmd_i.op == e_mret && state_i.priv != `PRIV_M));

   assign rdata_o = legal ? rval : '0;

   // Read-only space ignores writes
   assign wr_o.we   = legal && (cmd_i.addr[11:10] != 2'b11);
   assign wr_o.addr = cmd_i.addr;
   assign wr_o.data = wdata;

endmodule

`default_nettype wire

// File: trap_select.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_defines.svh"

module trap_select
(
   input  csr_pkg::csr_cmd_s   cmd_i,
   input  logic                cmd_v_i,
   input  csr_pkg::exc_vec_t   exc_i,
   input  csr_pkg::csr_state_s state_i,
   input  logic                timer_irq_i,
   input  logic                software_irq_i,
   input  logic                external_irq_i,
   output csr_pkg::trap_req_s  req_o,
   output logic                interrupt_ready_o
);
   import csr_pkg::*;

   exc_vec_t exc_all;
   exc_vec_t int_pend;
   logic     mgie;

   // Lowest set index wins
   function automatic logic [3:0] lowest_set(input logic [15:0] vec);
      logic [3:0] idx;
      idx = '0;
      for (int i = 15; i >= 0; i--)
      begin
         if (vec[i])
         begin
            idx = 4'(i);
         end
      end
      return idx;
   endfunction

   always_comb
   begin
      exc_all = exc_i;
      if (cmd_v_i && cmd_i.op == e_ecall)
      begin
         if (state_i.priv == `PRIV_M)
         begin
            exc_all[`CAUSE_ECALL_M] = 1'b1;
         end
         else
         begin
            exc_all[`CAUSE_ECALL_U] = 1'b1;
         end
      end
   end

   // Always enabled below M
   assign mgie = (state_i.priv != `PRIV_M) || state_i.mstatus.f.mie;

   always_comb
   begin
      int_pend     = '0;
      int_pend[3]  = software_irq_i & state_i.mie[3];
      int_pend[7]  = timer_irq_i & state_i.mie[7];
      int_pend[11] = external_irq_i & state_i.mie[11];
      int_pend     = int_pend & {16{mgie}};
   end

   assign req_o.exc_v    = |exc_all;
   assign req_o.exc_code = lowest_set(exc_all);
   assign req_o.int_v    = |int_pend;
   assign req_o.int_code = lowest_set(int_pend);

   assign interrupt_ready_o = |int_pend;

endmodule

`default_nettype wire

// File: trap_commit.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_defines.svh"

module trap_commit
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  csr_pkg::csr_cmd_s    cmd_i,
   input  logic                 cmd_v_i,
   input  csr_pkg::csr_write_s  wr_i,
   input  logic                 illegal_i,
   input  csr_pkg::trap_req_s   req_i,
   input  logic [`CSR_XLEN-1:0] pc_i,
   input  logic [`CSR_XLEN-1:0] npc_i,
   input  logic [`CSR_XLEN-1:0] instr_i,
   input  logic [`CSR_XLEN-1:0] vaddr_i,
   input  logic                 instret_i,
   input  logic                 interrupt_v_i,
   input  logic                 timer_irq_i,
   input  logic                 software_irq_i,
   input  logic                 external_irq_i,
   output csr_pkg::csr_state_s  state_o,
   output csr_pkg::commit_pkt_s commit_o
);
   import csr_pkg::*;

   csr_state_s           state_q;
   csr_state_s           state_n;
   logic                 take_int;
   logic                 take_exc;
   logic                 take_mret;
   logic [3:0]           exc_code;
   logic [`CSR_XLEN-1:0] npc;

   // Illegal only beats causes above 2
   assign exc_code = (illegal_i && (!req_i.exc_v || req_i.exc_code > `CAUSE_ILLEGAL))
                   ? `CAUSE_ILLEGAL : req_i.exc_code;

   assign take_int  = interrupt_v_i && req_i.int_v;
   assign take_exc  = !take_int && (req_i.exc_v || illegal_i);
   assign take_mret = !take_int && !take_exc && cmd_v_i && cmd_i.op == e_mret;

   always_comb
   begin
      state_n          = state_q;
      state_n.mip      = '0;
      state_n.mip[3]   = software_irq_i;
      state_n.mip[7]   = timer_irq_i;
      state_n.mip[11]  = external_irq_i;
      state_n.mcycle   = state_q.mcycle + {{(`CSR_XLEN-1){1'b0}}, 1'b1};
      state_n.minstret = state_q.minstret + {{(`CSR_XLEN-1){1'b0}}, instret_i};
      npc              = npc_i;

      if (take_int || take_exc)
      begin
         state_n.mepc = pc_i;
         if (take_int)
         begin
            state_n.mcause = {1'b1, {(`CSR_XLEN-5){1'b0}}, req_i.int_code};
            state_n.mtval  = '0;
         end
         else
         begin
            state_n.mcause = {{(`CSR_XLEN-4){1'b0}}, exc_code};
            if (exc_code == `CAUSE_ILLEGAL)
               state_n.mtval = instr_i;
            else if (exc_code inside {4'd0, 4'd1, [4'd4:4'd7]})
               state_n.mtval = vaddr_i;
            else
               state_n.mtval = '0;
         end
         state_n.mstatus.f.mpie = state_q.mstatus.f.mie;
         state_n.mstatus.f.mie  = 1'b0;
         state_n.mstatus.f.mpp  = state_q.priv;
         state_n.priv           = `PRIV_M;
         npc                    = state_q.mtvec;
      end
      else if (take_mret)
      begin
         state_n.priv           = state_q.mstatus.f.mpp;
         state_n.mstatus.f.mie  = state_q.mstatus.f.mpie;
         state_n.mstatus.f.mpie = 1'b1;
         state_n.mstatus.f.mpp  = `PRIV_U;
         npc                    = state_q.mepc;
      end
      else if (wr_i.we)
      begin
         case (wr_i.addr)
            `CSR_ADDR_MSTATUS:  state_n.mstatus.word = wr_i.data;
            `CSR_ADDR_MIE:      state_n.mie          = wr_i.data;
            `CSR_ADDR_MTVEC:    state_n.mtvec        = wr_i.data;
            `CSR_ADDR_MSCRATCH: state_n.mscratch     = wr_i.data;
            `CSR_ADDR_MEPC:     state_n.mepc         = wr_i.data;
            `CSR_ADDR_MCAUSE:   state_n.mcause       = wr_i.data;
            `CSR_ADDR_MTVAL:    state_n.mtval        = wr_i.data;
            `CSR_ADDR_MCYCLE:   state_n.mcycle       = wr_i.data;
            `CSR_ADDR_MINSTRET: state_n.minstret     = wr_i.data;
            default:            ;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q      <= '0;
         state_q.priv <= `PRIV_M;
      end
      else
      begin
         state_q <= state_n;
      end
   end

   assign state_o = state_q;

   assign commit_o.v         = take_int || take_exc || take_mret;
   assign commit_o.exception = take_exc;
   assign commit_o.interrupt = take_int;
   assign commit_o.eret      = take_mret;
   assign commit_o.npc       = npc;
   assign commit_o.priv_n    = state_n.priv;

   // An access flagged illegal must never also write
   assert property (@(posedge clk_i) disable iff (!rst_n_i) !(illegal_i && wr_i.we))
      else $error("CSR write issued together with an illegal access");

   // Only M and U exist
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_q.priv == `PRIV_M) || (state_q.priv == `PRIV_U))
      else $error("privilege holds a mode other than M or U");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_q.mstatus.word & ~`MSTATUS_MASK) == '0)
      else $error("reserved mstatus bits are set");

endmodule

`default_nettype wire

// File: csr_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_unit
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  csr_pkg::csr_cmd_s    cmd_i,
   input  logic                 cmd_v_i,
   input  csr_pkg::exc_vec_t    exc_i,
   input  logic [`CSR_XLEN-1:0] pc_i,
   input  logic [`CSR_XLEN-1:0] npc_i,
   input  logic [`CSR_XLEN-1:0] instr_i,
   input  logic [`CSR_XLEN-1:0] vaddr_i,
   input  logic                 instret_i,
   input  logic                 timer_irq_i,
   input  logic                 software_irq_i,
   input  logic                 external_irq_i,
   input  logic                 interrupt_v_i,
   output logic [`CSR_XLEN-1:0] csr_data_o,
   output logic                 interrupt_ready_o,
   output csr_pkg::commit_pkt_s commit_o
);
   import csr_pkg::*;

   csr_state_s state;
   csr_write_s wr;
   trap_req_s  req;
   logic       illegal;

   csr_access u_access
   (
      .cmd_i     (cmd_i),
      .cmd_v_i   (cmd_v_i),
      .state_i   (state),
      .rdata_o   (csr_data_o),
      .wr_o      (wr),
      .illegal_o (illegal)
   );

   trap_select u_trap_select
   (
      .cmd_i             (cmd_i),
      .cmd_v_i           (cmd_v_i),
      .exc_i             (exc_i),
      .state_i           (state),
      .timer_irq_i       (timer_irq_i),
      .software_irq_i    (software_irq_i),
      .external_irq_i    (external_irq_i),
      .req_o             (req),
      .interrupt_ready_o (interrupt_ready_o)
   );

   trap_commit u_trap_commit
   (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .cmd_i          (cmd_i),
      .cmd_v_i        (cmd_v_i),
      .wr_i           (wr),
      .illegal_i      (illegal),
      .req_i          (req),
      .pc_i           (pc_i),
      .npc_i          (npc_i),
      .instr_i        (instr_i),
      .vaddr_i        (vaddr_i),
      .instret_i      (instret_i),
      .interrupt_v_i  (interrupt_v_i),
      .timer_irq_i    (timer_irq_i),
      .software_irq_i (software_irq_i),
      .external_irq_i (external_irq_i),
      .state_o        (state),
      .commit_o       (commit_o)
   );

endmodule

`default_nettype wire

// File: tb_csr_model.svh
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// State after the last modelled clock edge
logic [1:0]                m_priv;
logic [31:0]               m_mstatus;
logic [31:0]               m_mie;
logic [31:0]               m_mip;
logic [31:0]               m_mtvec;
logic [31:0]               m_mscratch;
logic [31:0]               m_mepc;
logic [31:0]               m_mcause;
logic [31:0]               m_mtval;
logic [31:0]               m_minstret;

logic [31:0]               exp_rdata;
logic                      exp_rdata_known;
logic                      exp_ready;
csr_pkg::commit_pkt_s      exp_commit;

task automatic model_reset();
   m_priv     = `PRIV_M;
   m_mstatus  = '0;
   m_mie      = '0;
   m_mip      = '0;
   m_mtvec    = '0;
   m_mscratch = '0;
   m_mepc     = '0;
   m_mcause   = '0;
   m_mtval    = '0;
   m_minstret = '0;
endtask

function automatic logic [3:0] lowest_index(input logic [15:0] v);
   logic [3:0] code;
   logic       found;
   code  = '0;
   found = 1'b0;
   for (int i = 0; i < 16; i++)
   begin
      if (v[i] && !found)
      begin
         code  = 4'(i);
         found = 1'b1;
      end
   end
   return code;
endfunction

// mcycle is not tracked, so its reads are marked unknown
function automatic logic [31:0] model_read(input logic [11:0] addr, output logic ok,
                                           output logic known);
   ok         = 1'b1;
   known      = 1'b1;
   model_read = '0;
   case (addr)
      `CSR_ADDR_MSTATUS:   model_read = m_mstatus;
      `CSR_ADDR_MISA:      model_read = `MISA_VAL;
      `CSR_ADDR_MIE:       model_read = m_mie;
      `CSR_ADDR_MTVEC:     model_read = m_mtvec;
      `CSR_ADDR_MSCRATCH:  model_read = m_mscratch;
      `CSR_ADDR_MEPC:      model_read = m_mepc;
      `CSR_ADDR_MCAUSE:    model_read = m_mcause;
      `CSR_ADDR_MTVAL:     model_read = m_mtval;
      `CSR_ADDR_MIP:       model_read = m_mip;
      `CSR_ADDR_MCYCLE:    known      = 1'b0;
      `CSR_ADDR_MINSTRET:  model_read = m_minstret;
      `CSR_ADDR_MARCHID:   model_read = 32'd13;
      `CSR_ADDR_MIMPID:    model_read = 32'd1;
      `CSR_ADDR_MVENDORID,
      `CSR_ADDR_MHARTID:   model_read = '0;
      default:             ok         = 1'b0;
   endcase
endfunction

task automatic model_write(input logic [11:0] addr, input logic [31:0] val);
   case (addr)
      `CSR_ADDR_MSTATUS:
      begin
         // Only M or U can be held in mpp
         m_mstatus        = val & 32'h0000_0088;
         m_mstatus[12:11] = (val[12] && val[11]) ? 2'b11 : 2'b00;
      end
      `CSR_ADDR_MIE:      m_mie      = val & 32'h0000_0888;
      `CSR_ADDR_MTVEC:    m_mtvec    = val & 32'hFFFF_FFFC;
      `CSR_ADDR_MSCRATCH: m_mscratch = val;
      `CSR_ADDR_MEPC:     m_mepc     = val & 32'hFFFF_FFFE;
      `CSR_ADDR_MCAUSE:   m_mcause   = val;
      `CSR_ADDR_MTVAL:    m_mtval    = val;
      `CSR_ADDR_MINSTRET: m_minstret = val;
      default:            m_mtval    = m_mtval;
   endcase
endtask

// Expected outputs for the current stimulus, then the state after the edge
task automatic model_step();
   logic [31:0] rval;
   logic [31:0] src;
   logic [31:0] wval;
   logic [15:0] exc;
   logic [15:0] pend;
   logic [3:0]  code;
   logic        ok;
   logic        known;
   logic        is_csr;
   logic        is_imm;
   logic        legal;
   logic        illegal;
   logic        take_int;
   logic        take_exc;
   logic        take_mret;

   rval    = model_read(st_cmd.addr, ok, known);
   is_csr  = st_cmd_v && (st_cmd.op inside {e_csrrw, e_csrrs, e_csrrc,
                                            e_csrrwi, e_csrrsi, e_csrrci});
   is_imm  = st_cmd.op inside {e_csrrwi, e_csrrsi, e_csrrci};
   legal   = is_csr && ok && (m_priv >= st_cmd.addr[9:8]);
   illegal = (is_csr && !legal)
           || (st_cmd_v && st_cmd.op == e_mret && m_priv != `PRIV_M);
   src     = is_imm ? {27'b0, st_cmd.data[4:0]} : st_cmd.data;
   case (st_cmd.op)
      e_csrrw, e_csrrwi: wval = src;
      e_csrrs, e_csrrsi: wval = rval | src;
      e_csrrc, e_csrrci: wval = rval & ~src;
      default:           wval = rval;
   endcase
   exp_rdata       = legal ? rval : '0;
   exp_rdata_known = !legal || known;

   exc = st_exc;
   if (st_cmd_v && st_cmd.op == e_ecall)
   begin
      if (m_priv == `PRIV_M)
         exc[`CAUSE_ECALL_M] = 1'b1;
      else
         exc[`CAUSE_ECALL_U] = 1'b1;
   end
   pend     = '0;
   pend[3]  = st_software_irq & m_mie[3];
   pend[7]  = st_timer_irq & m_mie[7];
   pend[11] = st_external_irq & m_mie[11];
   if (m_priv == `PRIV_M && !m_mstatus[3])
      pend = '0;
   exp_ready = |pend;

   take_int  = st_interrupt_v && exp_ready;
   take_exc  = !take_int && ((|exc) || illegal);
   take_mret = !take_int && !take_exc && st_cmd_v && st_cmd.op == e_mret;
   code      = lowest_index(exc);
   if (illegal && (exc == '0 || code > 4'd2))
      code = `CAUSE_ILLEGAL;

   exp_commit     = '0;
   exp_commit.npc = st_npc;
   m_minstret     = m_minstret + 32'(st_instret);
   m_mip          = '0;
   m_mip[3]       = st_software_irq;
   m_mip[7]       = st_timer_irq;
   m_mip[11]      = st_external_irq;

   if (take_int || take_exc)
   begin
      m_mepc = st_pc;
      if (take_int)
      begin
         m_mcause = {1'b1, 27'b0, lowest_index(pend)};
         m_mtval  = '0;
      end
      else
      begin
         m_mcause = {28'b0, code};
         if (code == `CAUSE_ILLEGAL)
            m_mtval = st_instr;
         else if (code inside {4'd0, 4'd1, [4'd4:4'd7]})
            m_mtval = st_vaddr;
         else
            m_mtval = '0;
      end
      m_mstatus[7]     = m_mstatus[3];
      m_mstatus[3]     = 1'b0;
      m_mstatus[12:11] = m_priv;
      m_priv           = `PRIV_M;
      exp_commit.npc   = m_mtvec;
   end
   else if (take_mret)
   begin
      m_priv           = m_mstatus[12:11];
      m_mstatus[3]     = m_mstatus[7];
      m_mstatus[7]     = 1'b1;
      m_mstatus[12:11] = `PRIV_U;
      exp_commit.npc   = m_mepc;
   end
   else if (legal && st_cmd.addr[11:10] != 2'b11)
   begin
      model_write(st_cmd.addr, wval);
   end

   exp_commit.v         = take_int || take_exc || take_mret;
   exp_commit.exception = take_exc;
   exp_commit.interrupt = take_int;
   exp_commit.eret      = take_mret;
   exp_commit.priv_n    = m_priv;
endtask

`endif

// File: tb_csr_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "csr_defines.svh"

module tb_csr_unit;
   import csr_pkg::*;

   // Reset, then tests 1 to 6 in cycles
   localparam int TEST_CYCLES = 5 + 8 + 300 + 40 * 5 + 14 + 60 * 8 + 80;
   localparam int LIMIT       = 2 * TEST_CYCLES;

   logic                 clk;
   logic                 rst_n;
   csr_cmd_s             cmd;
   logic                 cmd_v;
   exc_vec_t             exc;
   logic [31:0]          pc;
   logic [31:0]          npc;
   logic [31:0]          instr;
   logic [31:0]          vaddr;
   logic                 instret;
   logic                 timer_irq;
   logic                 software_irq;
   logic                 external_irq;
   logic                 interrupt_v;
   logic [31:0]          csr_data;
   logic                 interrupt_ready;
   commit_pkt_s          commit;

   // Stimulus for the next cycle
   csr_cmd_s             st_cmd;
   logic                 st_cmd_v;
   exc_vec_t             st_exc;
   logic [31:0]          st_pc;
   logic [31:0]          st_npc;
   logic [31:0]          st_instr;
   logic [31:0]          st_vaddr;
   logic                 st_instret;
   logic                 st_timer_irq;
   logic                 st_software_irq;
   logic                 st_external_irq;
   logic                 st_interrupt_v;

   int                   cycle_count = 0;
   int                   errors = 0;
   int                   checks = 0;
   int                   tests = 0;
   int                   test_errors = 0;
   int                   gap;
   logic                 user;
   logic                 taken;
   logic [31:0]          last_rdata;
   logic [31:0]          saved;
   logic [31:0]          first;
   logic [31:0]          count;
   logic [11:0]          wr_addrs [7] = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
                                          `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC,
                                          `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL};
   csr_op_e              csr_ops [6] = '{e_csrrw, e_csrrs, e_csrrc, e_csrrwi, e_csrrsi,
                                         e_csrrci};

`include "tb_csr_model.svh"

   csr_unit u_csr_unit
   (
      .clk_i             (clk),
      .rst_n_i           (rst_n),
      .cmd_i             (cmd),
      .cmd_v_i           (cmd_v),
      .exc_i             (exc),
      .pc_i              (pc),
      .npc_i             (npc),
      .instr_i           (instr),
      .vaddr_i           (vaddr),
      .instret_i         (instret),
      .timer_irq_i       (timer_irq),
      .software_irq_i    (software_irq),
      .external_irq_i    (external_irq),
      .interrupt_v_i     (interrupt_v),
      .csr_data_o        (csr_data),
      .interrupt_ready_o (interrupt_ready),
      .commit_o          (commit)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= LIMIT)
      begin
         $display("Timeout: the run did not end within %0d cycles", LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
      checks = checks + 1;
      if (got !== exp)
      begin
         errors = errors + 1;
         $display("CHECK FAILED at time %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
      end
   endtask

   task automatic set_idle();
      st_cmd         = '0;
      st_cmd_v       = 1'b0;
      st_exc         = '0;
      st_instret     = 1'b0;
      st_interrupt_v = 1'b0;
      st_pc          = $urandom;
      st_npc         = $urandom;
      st_instr       = $urandom;
      st_vaddr       = $urandom;
   endtask

   // Drive on the rising edge, compare on the falling edge
   task automatic run_cycle(input string what);
      @(posedge clk);
      cmd          <= st_cmd;
      cmd_v        <= st_cmd_v;
      exc          <= st_exc;
      pc           <= st_pc;
      npc          <= st_npc;
      instr        <= st_instr;
      vaddr        <= st_vaddr;
      instret      <= st_instret;
      timer_irq    <= st_timer_irq;
      software_irq <= st_software_irq;
      external_irq <= st_external_irq;
      interrupt_v  <= st_interrupt_v;
      @(negedge clk);
      model_step();
      if (exp_rdata_known)
         check(64'(csr_data), 64'(exp_rdata), {what, ": csr_data_o"});
      check(64'(interrupt_ready), 64'(exp_ready), {what, ": interrupt_ready_o"});
      check(64'(commit), 64'(exp_commit), {what, ": commit_o"});
      last_rdata = csr_data;
      set_idle();
   endtask

   task automatic do_csr(input csr_op_e op, input logic [11:0] addr, input logic [31:0] data,
                         input string what);
      st_cmd.op   = op;
      st_cmd.addr = addr;
      st_cmd.data = data;
      st_cmd_v    = 1'b1;
      run_cycle(what);
   endtask

   task automatic read_csr(input logic [11:0] addr);
      do_csr(e_csrrs, addr, '0, $sformatf("read %h", addr));
   endtask

   task automatic end_test(input string name);
      if (errors == test_errors)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d mismatches", name, errors - test_errors);
      tests       = tests + 1;
      test_errors = errors;
   endtask

   initial
   begin
      void'($urandom(86500));
      clk             = 1'b0;
      rst_n           = 1'b0;
      cmd             = '0;
      cmd_v           = 1'b0;
      exc             = '0;
      pc              = '0;
      npc             = '0;
      instr           = '0;
      vaddr           = '0;
      instret         = 1'b0;
      timer_irq       = 1'b0;
      software_irq    = 1'b0;
      external_irq    = 1'b0;
      interrupt_v     = 1'b0;
      st_timer_irq    = 1'b0;
      st_software_irq = 1'b0;
      st_external_irq = 1'b0;
      set_idle();
      model_reset();
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      read_csr(`CSR_ADDR_MSTATUS);
      check(64'(last_rdata), 64'd0, "mstatus after reset");
      read_csr(`CSR_ADDR_MIE);
      check(64'(last_rdata), 64'd0, "mie after reset");
      read_csr(`CSR_ADDR_MEPC);
      check(64'(last_rdata), 64'd0, "mepc after reset");
      read_csr(`CSR_ADDR_MVENDORID);
      check(64'(last_rdata), 64'd0, "mvendorid");
      read_csr(`CSR_ADDR_MARCHID);
      check(64'(last_rdata), 64'd13, "marchid");
      read_csr(`CSR_ADDR_MIMPID);
      check(64'(last_rdata), 64'd1, "mimpid");
      read_csr(`CSR_ADDR_MISA);
      check(64'(last_rdata), 64'(`MISA_VAL), "misa");
      read_csr(`CSR_ADDR_MHARTID);
      check(64'(last_rdata), 64'd0, "mhartid");
      end_test("reset and constants");

      for (int i = 0; i < 300; i++)
      begin
         do_csr(csr_ops[$urandom_range(5)], wr_addrs[$urandom_range(6)], $urandom,
                "random csr op");
      end
      end_test("random csr operations");

      for (int i = 0; i < 40; i++)
      begin
         st_exc = 16'd1 << $urandom_range(15);
         if ($urandom_range(3) == 0)
            st_exc = st_exc | (16'd1 << $urandom_range(15));
         if ($urandom_range(3) == 0)
         begin
            st_exc    = '0;
            st_cmd.op = e_ecall;
            st_cmd_v  = 1'b1;
         end
         run_cycle("exception");
         check(64'(commit.exception), 64'd1, "exception flag");
         check(64'(commit.npc), 64'(m_mtvec), "exception npc");
         check(64'(commit.priv_n), 64'(`PRIV_M), "exception priv_n");
         read_csr(`CSR_ADDR_MCAUSE);
         read_csr(`CSR_ADDR_MEPC);
         read_csr(`CSR_ADDR_MTVAL);
         read_csr(`CSR_ADDR_MSTATUS);
      end
      end_test("exceptions and ecall");

      read_csr(`CSR_ADDR_MSCRATCH);
      saved = last_rdata;
      do_csr(e_csrrw, `CSR_ADDR_MEPC, $urandom, "set mepc");
      // mpie set, mpp back to U
      do_csr(e_csrrw, `CSR_ADDR_MSTATUS, 32'h0000_0080, "set mstatus");
      do_csr(e_mret, '0, '0, "mret");
      check(64'(commit.eret), 64'd1, "mret eret flag");
      check(64'(commit.npc), 64'(m_mepc), "mret npc");
      check(64'(commit.priv_n), 64'(`PRIV_U), "mret priv_n");
      first = st_instr;
      do_csr(e_csrrw, `CSR_ADDR_MSCRATCH, $urandom, "user access to mscratch");
      check(64'(commit.exception), 64'd1, "user access traps");
      read_csr(`CSR_ADDR_MCAUSE);
      check(64'(last_rdata), 64'd2, "illegal cause");
      read_csr(`CSR_ADDR_MTVAL);
      check(64'(last_rdata), 64'(first), "illegal mtval");
      read_csr(`CSR_ADDR_MSCRATCH);
      check(64'(last_rdata), 64'(saved), "mscratch unchanged");
      do_csr(e_mret, '0, '0, "mret");
      do_csr(e_mret, '0, '0, "mret in user mode");
      read_csr(`CSR_ADDR_MCAUSE);
      check(64'(last_rdata), 64'd2, "mret in user mode cause");
      do_csr(e_mret, '0, '0, "mret");
      do_csr(e_ecall, '0, '0, "ecall in user mode");
      read_csr(`CSR_ADDR_MCAUSE);
      check(64'(last_rdata), 64'(`CAUSE_ECALL_U), "user ecall cause");
      end_test("mret and user mode");

      for (int i = 0; i < 60; i++)
      begin
         do_csr(e_csrrw, `CSR_ADDR_MIE, $urandom, "set mie");
         user = ($urandom_range(1) == 1);
         if (user)
         begin
            do_csr(e_csrrw, `CSR_ADDR_MSTATUS, 32'h0, "clear mstatus");
            do_csr(e_mret, '0, '0, "mret to user");
         end
         else
         begin
            do_csr(e_csrrw, `CSR_ADDR_MSTATUS,
                   ($urandom_range(1) == 1) ? 32'h0000_1808 : 32'h0000_1800, "set mstatus");
         end
         st_timer_irq    = 1'($urandom_range(1));
         st_software_irq = 1'($urandom_range(1));
         st_external_irq = 1'($urandom_range(1));
         run_cycle("irq lines");
         st_interrupt_v = 1'b1;
         saved          = st_pc;
         run_cycle("interrupt");
         taken = exp_commit.interrupt;
         // Nothing taken in U, so climb back with an ECALL
         if (m_priv == `PRIV_U)
            do_csr(e_ecall, '0, '0, "ecall back to machine mode");
         if (taken)
         begin
            read_csr(`CSR_ADDR_MCAUSE);
            check(64'(last_rdata[31]), 64'd1, "interrupt bit of mcause");
            read_csr(`CSR_ADDR_MEPC);
            check(64'(last_rdata), 64'(saved), "interrupt mepc");
         end
      end
      st_timer_irq    = 1'b0;
      st_software_irq = 1'b0;
      st_external_irq = 1'b0;
      end_test("interrupts");

      do_csr(e_csrrw, `CSR_ADDR_MINSTRET, '0, "clear minstret");
      count = '0;
      for (int i = 0; i < 50; i++)
      begin
         st_instret = 1'($urandom_range(1));
         count      = count + 32'(st_instret);
         run_cycle("instret");
      end
      read_csr(`CSR_ADDR_MINSTRET);
      check(64'(last_rdata), 64'(count), "minstret count");
      read_csr(`CSR_ADDR_MCYCLE);
      first = last_rdata;
      gap   = 5 + $urandom_range(15);
      repeat (gap - 1) run_cycle("idle");
      read_csr(`CSR_ADDR_MCYCLE);
      // The first read writes mcycle back, which holds it for one edge
      check(64'(last_rdata - first), 64'(gap - 1), "mcycle difference");
      end_test("counters");

      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: csr_unit.f
+incdir+.
csr_pkg.sv
csr_access.sv
trap_select.sv
trap_commit.sv
csr_unit.sv
tb_csr_unit.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_csr_unit -f csr_unit.f
	./obj_dir/Vtb_csr_unit | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
